//--- Makefile
# Verilator build and run of the keypad word testbench
VERILATOR ?= verilator
TOP       ?= keypad_word_tb
FILELIST  ?= keypad_word.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)

//--- design/key_scanner.sv
`timescale 1ns/1ns
module key_scanner (
  input  logic                  clk,
  input  logic                  nRst,
  input  logic                  step,
  input  logic                  sweep_end,
  input  keypad_pkg::col_idx_t  col_idx,
  input  keypad_pkg::nibble_t   row,
  output keypad_pkg::nibble_t   col,
  output keypad_pkg::key_code_t key,
  output logic                  strobe
);

  keypad_pkg::key_code_t cand;        // First hit of the sweep in progress
  keypad_pkg::key_code_t sweep_code;  // Result of the sweep closing now
  keypad_pkg::key_code_t last_sweep;  // Result of the previous sweep
  logic [1:0]            match_cnt;   // Run length of equal sweeps
  logic [1:0]            next_cnt;
  logic                  key_was_nz;  // Key level one cycle back

  // One-hot column drive, column 0 on the MSB
  assign col = 4'b1000 >> col_idx;

  // Earlier hit wins, else take what column 3 shows
  always_comb begin
    if (cand != '0) begin
      sweep_code = cand;
    end else if (row != '0) begin
      sweep_code = {row, col};
    end else begin
      sweep_code = '0;
    end
  end

  // Run length, saturates at the top
  always_comb begin
    if (sweep_code != last_sweep) begin
      next_cnt = 2'd1;                 // New code starts a fresh run
    end else if (match_cnt == '1) begin
      next_cnt = match_cnt;
    end else begin
      next_cnt = match_cnt + 2'd1;
    end
  end

  // Sweep capture and debounce
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      cand       <= '0;
      last_sweep <= '0;
      match_cnt  <= '0;
      key        <= '0;
    end else if (step) begin
      if (sweep_end) begin
        cand       <= '0;              // Next sweep starts clean
        last_sweep <= sweep_code;
        match_cnt  <= next_cnt;
        if (next_cnt >= 2'(keypad_pkg::DEBOUNCE_SWEEPS)) begin
          key <= sweep_code;           // Stable long enough
        end
      end else if (cand == '0 && row != '0) begin
        cand <= {row, col};            // Latch first key seen
      end
    end
  end

  // Press strobe, one cycle after key leaves zero
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      key_was_nz <= 1'b0;
      strobe     <= 1'b0;
    end else begin
      key_was_nz <= |key;
      strobe     <= |key && !key_was_nz;
    end
  end

endmodule

//--- design/keypad_pkg.sv
package keypad_pkg;

  // Key code is {row one-hot, column one-hot}, index 0 on the MSB
  typedef logic [7:0] key_code_t;   // Zero when no key is down
  typedef logic [3:0] nibble_t;     // One-hot row or column
  typedef logic [1:0] col_idx_t;    // Binary column number

  // Scan timing
  localparam int SCAN_DIV        = 4;                  // Clocks per column step
  localparam int SCAN_DIV_W      = $clog2(SCAN_DIV);   // Divider counter width
  localparam int DEBOUNCE_SWEEPS = 2;                  // Equal sweeps to accept a change

  // Row 0
  localparam key_code_t KEY_1    = 8'b1000_1000;
  localparam key_code_t KEY_2    = 8'b1000_0100;  // ABC
  localparam key_code_t KEY_3    = 8'b1000_0010;  // DEF
  localparam key_code_t KEY_A    = 8'b1000_0001;
  // Row 1
  localparam key_code_t KEY_4    = 8'b0100_1000;  // GHI
  localparam key_code_t KEY_5    = 8'b0100_0100;  // JKL
  localparam key_code_t KEY_6    = 8'b0100_0010;  // MNO
  localparam key_code_t KEY_B    = 8'b0100_0001;
  // Row 2
  localparam key_code_t KEY_7    = 8'b0010_1000;  // PQRS
  localparam key_code_t KEY_8    = 8'b0010_0100;  // TUV
  localparam key_code_t KEY_9    = 8'b0010_0010;  // WXYZ
  localparam key_code_t KEY_C    = 8'b0010_0001;  // Game end
  // Row 3
  localparam key_code_t KEY_STAR = 8'b0001_1000;  // Submit letter
  localparam key_code_t KEY_0    = 8'b0001_0100;  // Clear letter
  localparam key_code_t KEY_HASH = 8'b0001_0010;  // Submit word
  localparam key_code_t KEY_D    = 8'b0001_0001;

  // Multi-tap FSM, TAPn selects the n-th letter of the key
  typedef enum logic [2:0] {
    IDLE, TAP0, TAP1, TAP2, TAP3, DONE
  } tap_state_t;

endpackage

//--- design/keypad_word_top.sv
`timescale 1ns/1ns
module keypad_word_top (
  input  logic                  clk,
  input  logic                  nRst,
  input  keypad_pkg::nibble_t   row,
  output keypad_pkg::nibble_t   col,
  output text_pkg::char_t       letter,
  output logic                  letter_valid,
  output text_pkg::word_t       word,
  output text_pkg::word_count_t word_count,
  output logic                  word_valid,
  output logic                  game_over
);

  logic                  step;         // Column step tick
  logic                  sweep_end;    // Last step of a sweep
  keypad_pkg::col_idx_t  col_idx;
  keypad_pkg::key_code_t key;          // Debounced key level
  logic                  strobe;       // New press
  logic                  word_submit;
  logic                  game_end;

  scan_timer u_timer (
    .clk, .nRst, .step, .sweep_end, .col_idx
  );

  key_scanner u_scanner (
    .clk, .nRst, .step, .sweep_end, .col_idx,
    .row, .col, .key, .strobe
  );

  multitap_fsm u_fsm (
    .clk, .nRst, .strobe, .key,
    .letter, .letter_valid, .word_submit, .game_end
  );

  word_buffer u_buffer (
    .clk, .nRst, .letter, .letter_valid, .word_submit, .game_end,
    .word, .word_count, .word_valid, .game_over
  );

endmodule

//--- design/multitap_fsm.sv
`timescale 1ns/1ns
module multitap_fsm (
  input  logic                  clk,
  input  logic                  nRst,
  input  logic                  strobe,
  input  keypad_pkg::key_code_t key,
  output text_pkg::char_t       letter,
  output logic                  letter_valid,
  output logic                  word_submit,
  output logic                  game_end
);

  keypad_pkg::tap_state_t state, next_state;
  keypad_pkg::key_code_t  prev_key;     // Last digit key with letters
  text_pkg::char_t        next_letter;
  text_pkg::char_t        base;         // First letter of the pressed key
  logic                   letter_key;   // Press of a key 2 to 9
  logic                   four_letter;  // Keys 7 and 9 carry a fourth letter
  logic                   tapping;      // A letter is pending

  // First letter of each digit key, zero for all others
  function automatic text_pkg::char_t base_char(input keypad_pkg::key_code_t k);
    text_pkg::char_t c;
    case (k)
      keypad_pkg::KEY_2: c = "A";
      keypad_pkg::KEY_3: c = "D";
      keypad_pkg::KEY_4: c = "G";
      keypad_pkg::KEY_5: c = "J";
      keypad_pkg::KEY_6: c = "M";
      keypad_pkg::KEY_7: c = "P";
      keypad_pkg::KEY_8: c = "T";
      keypad_pkg::KEY_9: c = "W";
      default:           c = 8'd0;
    endcase
    return c;
  endfunction

  // Offset of the selected letter within its key
  function automatic text_pkg::char_t tap_offset(input keypad_pkg::tap_state_t s);
    text_pkg::char_t o;
    case (s)
      keypad_pkg::TAP1: o = 8'd1;
      keypad_pkg::TAP2: o = 8'd2;
      keypad_pkg::TAP3: o = 8'd3;
      default:          o = 8'd0;
    endcase
    return o;
  endfunction

  assign base        = base_char(key);
  assign letter_key  = strobe && (base != '0);
  assign four_letter = (key == keypad_pkg::KEY_7) || (key == keypad_pkg::KEY_9);
  assign tapping     = (state == keypad_pkg::TAP0) || (state == keypad_pkg::TAP1) ||
                       (state == keypad_pkg::TAP2) || (state == keypad_pkg::TAP3);

  always_comb begin
    next_state  = state;
    next_letter = letter;
    word_submit = 1'b0;
    game_end    = 1'b0;

    // DONE lasts one cycle
    if (state == keypad_pkg::DONE) begin
      next_state  = keypad_pkg::IDLE;
      next_letter = '0;
    end

    // Keys act on the press strobe only
    if (strobe) begin
      case (key)
        keypad_pkg::KEY_STAR: begin
          if (tapping) next_state = keypad_pkg::DONE;  // Letter already held
        end
        keypad_pkg::KEY_0: begin
          next_state  = keypad_pkg::IDLE;              // Drop pending letter
          next_letter = '0;
        end
        keypad_pkg::KEY_HASH: begin
          word_submit = 1'b1;                          // Pending letter is discarded
          next_state  = keypad_pkg::IDLE;
          next_letter = '0;
        end
        keypad_pkg::KEY_C: begin
          game_end    = 1'b1;
          next_state  = keypad_pkg::IDLE;
          next_letter = '0;
        end
        keypad_pkg::KEY_1, keypad_pkg::KEY_A,
        keypad_pkg::KEY_B, keypad_pkg::KEY_D: begin
          next_state = state;                          // No effect
        end
        default: begin
          if (letter_key) begin
            if (tapping && key == prev_key) begin
              // Same key again, cycle through its letters
              case (state)
                keypad_pkg::TAP0: next_state = keypad_pkg::TAP1;
                keypad_pkg::TAP1: next_state = keypad_pkg::TAP2;
                keypad_pkg::TAP2: next_state = four_letter ? keypad_pkg::TAP3
                                                           : keypad_pkg::TAP0;
                default:          next_state = keypad_pkg::TAP0;
              endcase
            end else begin
              next_state = keypad_pkg::TAP0;           // New key restarts
            end
            next_letter = base + tap_offset(next_state);
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      state        <= keypad_pkg::IDLE;
      letter       <= '0;
      letter_valid <= 1'b0;
      prev_key     <= '0;
    end else begin
      state        <= next_state;
      letter       <= next_letter;
      letter_valid <= (next_state == keypad_pkg::DONE);  // Aligned with DONE
      if (letter_key) prev_key <= key;
    end
  end

endmodule

//--- design/scan_timer.sv
`timescale 1ns/1ns
module scan_timer (
  input  logic                 clk,
  input  logic                 nRst,
  output logic                 step,
  output logic                 sweep_end,
  output keypad_pkg::col_idx_t col_idx
);

  logic [keypad_pkg::SCAN_DIV_W-1:0] div_cnt;  // Clock within current column

  // Last clock of a column slot, rows have settled by now
  assign step      = (int'(div_cnt) == keypad_pkg::SCAN_DIV - 1);
  // Step that closes column 3 ends the sweep
  assign sweep_end = step && (col_idx == 2'd3);

  // Free-running divider
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      div_cnt <= '0;
    end else if (step) begin
      div_cnt <= '0;                   // Wrap at SCAN_DIV
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Column counter, wraps once per sweep
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      col_idx <= '0;                   // Column 0 after reset
    end else if (step) begin
      col_idx <= col_idx + 2'd1;
    end
  end

endmodule

//--- design/text_pkg.sv
package text_pkg;

  // One ASCII character
  typedef logic [7:0] char_t;

  // Longest word the buffer holds
  localparam int WORD_LEN = 5;

  // Packed word, character 0 in the lowest byte
  // Bytes past the stored count stay zero
  typedef logic [8*WORD_LEN-1:0] word_t;

  // Number of stored characters, 0 to WORD_LEN
  typedef logic [2:0] word_count_t;

endpackage

//--- design/word_buffer.sv
`timescale 1ns/1ns
module word_buffer (
  input  logic                  clk,
  input  logic                  nRst,
  input  text_pkg::char_t       letter,
  input  logic                  letter_valid,
  input  logic                  word_submit,
  input  logic                  game_end,
  output text_pkg::word_t       word,
  output text_pkg::word_count_t word_count,
  output logic                  word_valid,
  output logic                  game_over
);

  logic room;     // Space left for another letter
  logic append;   // Store the incoming letter this cycle

  assign room   = word_count < text_pkg::word_count_t'(text_pkg::WORD_LEN);
  assign append = letter_valid && !game_over && room;  // Full buffer drops it

  // Submit pulse, word and count are live during it
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      word_valid <= 1'b0;
    end else begin
      word_valid <= word_submit && !game_over;
    end
  end

  // Game end latches until reset
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      game_over <= 1'b0;
    end else if (game_end) begin
      game_over <= 1'b1;
    end
  end

  // Letter storage
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      word       <= '0;
      word_count <= '0;
    end else if (game_end || word_valid) begin
      word       <= '0;                         // Clear after publish or at game end
      word_count <= '0;
    end else if (append) begin
      word[8*word_count +: 8] <= letter;        // Next free byte
      word_count              <= word_count + 3'd1;
    end
  end

endmodule

//--- keypad_word.f
design/keypad_pkg.sv
design/text_pkg.sv
design/scan_timer.sv
design/key_scanner.sv
design/multitap_fsm.sv
design/word_buffer.sv
design/keypad_word_top.sv
tests/keypad_word_assert.sv
tests/keypad_word_tb.sv

//--- tests/keypad_word_assert.sv
`timescale 1ns/1ns
module keypad_word_assert (
  input logic                  clk,
  input logic                  nRst,
  input keypad_pkg::nibble_t   col,
  input keypad_pkg::key_code_t key,
  input logic                  strobe,
  input text_pkg::char_t       letter,
  input logic                  letter_valid
);

  int fail_cnt = 0;  // Number of failed assertions

  col_one_hot: assert property (@(posedge clk) disable iff (!nRst) $onehot(col))
    else begin
      fail_cnt++;
      $error("col is not one-hot");
    end

  strobe_with_key: assert property (@(posedge clk) disable iff (!nRst) strobe |-> key != '0)
    else begin
      fail_cnt++;
      $error("strobe high while key is zero");
    end

  // A pulse and never a level
  letter_one_cycle: assert property (@(posedge clk) disable iff (!nRst)
                                     letter_valid |=> !letter_valid)
    else begin
      fail_cnt++;
      $error("letter_valid longer than one cycle");
    end

  letter_nonzero: assert property (@(posedge clk) disable iff (!nRst)
                                   letter_valid |-> letter != '0)
    else begin
      fail_cnt++;
      $error("letter_valid with zero letter");
    end

endmodule

// Scanner instance with letter inputs held idle
bind key_scanner keypad_word_assert u_scan_assert (
  .clk(clk), .nRst(nRst), .col(col), .key(key), .strobe(strobe),
  .letter(8'h00), .letter_valid(1'b0)
);

// FSM instance with the column input held on column 0
bind multitap_fsm keypad_word_assert u_fsm_assert (
  .clk(clk), .nRst(nRst), .col(4'b1000), .key(key), .strobe(strobe),
  .letter(letter), .letter_valid(letter_valid)
);

//--- tests/keypad_word_tb.sv
`timescale 1ns/1ns
module keypad_word_tb;

  localparam int SWEEP_CYCLES = 4 * keypad_pkg::SCAN_DIV;  // Four columns per sweep
  localparam int HOLD_CYCLES  = (keypad_pkg::DEBOUNCE_SWEEPS + 3) * SWEEP_CYCLES;
  localparam int PRESS_CYCLES = 2 * HOLD_CYCLES + 4 * SWEEP_CYCLES;  // Hold, release, pulse wait
  localparam int ROUNDS       = 12;                         // Random multi-tap rounds
  localparam int MAX_PRESSES  = 8 * ROUNDS + 40;
  localparam int TIMEOUT_NS   = (MAX_PRESSES * PRESS_CYCLES + 200) * 8;

  localparam keypad_pkg::key_code_t LETTER_KEYS[8] = '{
    keypad_pkg::KEY_2, keypad_pkg::KEY_3, keypad_pkg::KEY_4, keypad_pkg::KEY_5,
    keypad_pkg::KEY_6, keypad_pkg::KEY_7, keypad_pkg::KEY_8, keypad_pkg::KEY_9
  };
  localparam keypad_pkg::key_code_t IGNORED_KEYS[4] = '{
    keypad_pkg::KEY_1, keypad_pkg::KEY_A, keypad_pkg::KEY_B, keypad_pkg::KEY_D
  };

  logic                  clk;
  logic                  nRst;
  keypad_pkg::nibble_t   row;
  keypad_pkg::nibble_t   col;
  text_pkg::char_t       letter;
  logic                  letter_valid;
  text_pkg::word_t       word;
  text_pkg::word_count_t word_count;
  logic                  word_valid;
  logic                  game_over;

  keypad_pkg::key_code_t pressed;          // Key held on the matrix or zero for none
  int                    seed = 11;

  // Reference model
  keypad_pkg::key_code_t pend_key;         // Pending letter key
  int                    taps;             // Presses of the pending key
  text_pkg::char_t       exp_q[$];         // Letters of the word in progress
  logic                  model_over;

  // Pulses seen on the outputs
  int                    letter_seen = 0;
  int                    word_seen   = 0;
  text_pkg::char_t       got_letter;
  text_pkg::word_t       got_word;
  text_pkg::word_count_t got_count;

  keypad_word_top dut (
    .clk(clk), .nRst(nRst), .row(row), .col(col), .letter(letter),
    .letter_valid(letter_valid), .word(word), .word_count(word_count),
    .word_valid(word_valid), .game_over(game_over)
  );

  // Closed switch connects its row to its column
  assign row = (col == pressed[3:0]) ? pressed[7:4] : 4'b0000;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Capture output pulses mid-cycle
  always @(negedge clk) begin
    if (letter_valid) begin
      letter_seen++;
      got_letter = letter;
    end
    if (word_valid) begin
      word_seen++;
      got_word  = word;
      got_count = word_count;
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "run stopped at first failure");
  endtask

  // Stop at the first failed bound assertion
  always @(negedge clk) begin
    if (dut.u_scanner.u_scan_assert.fail_cnt != 0 ||
        dut.u_fsm.u_fsm_assert.fail_cnt != 0) begin
      abort_run("A bound assertion failed");
    end
  end

  task automatic check_char(input text_pkg::char_t got, input text_pkg::char_t want,
                            input string what);
    if (got !== want) begin
      abort_run($sformatf("error at %0t ns: %s is 0x%02h, expected 0x%02h",
                          $time, what, got, want));
    end
  endtask

  task automatic check_word(input text_pkg::word_t got, input text_pkg::word_t want,
                            input string what);
    if (got !== want) begin
      abort_run($sformatf("error at %0t ns: %s is 0x%h, expected 0x%h",
                          $time, what, got, want));
    end
  endtask

  task automatic check_count(input text_pkg::word_count_t got,
                             input text_pkg::word_count_t want, input string what);
    if (got !== want) begin
      abort_run($sformatf("error at %0t ns: %s is %0d, expected %0d",
                          $time, what, got, want));
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string what);
    if (got !== want) begin
      abort_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, what, got, want));
    end
  endtask

  // Letters printed on each digit key
  function automatic string key_letters(input keypad_pkg::key_code_t k);
    string s;
    case (k)
      keypad_pkg::KEY_2: s = "ABC";
      keypad_pkg::KEY_3: s = "DEF";
      keypad_pkg::KEY_4: s = "GHI";
      keypad_pkg::KEY_5: s = "JKL";
      keypad_pkg::KEY_6: s = "MNO";
      keypad_pkg::KEY_7: s = "PQRS";
      keypad_pkg::KEY_8: s = "TUV";
      keypad_pkg::KEY_9: s = "WXYZ";
      default:           s = "";
    endcase
    return s;
  endfunction

  // Update the model and press the key once before comparing
  task automatic do_press(input keypad_pkg::key_code_t k);
    string                 letters;
    logic                  exp_lv;
    logic                  exp_wv;
    text_pkg::char_t       exp_ch;
    text_pkg::word_t       exp_w;
    text_pkg::word_count_t exp_n;
    int                    lc0;
    int                    wc0;
    letters = key_letters(k);
    exp_lv  = 1'b0;
    exp_wv  = 1'b0;
    exp_ch  = '0;
    exp_w   = '0;
    exp_n   = '0;
    if (letters.len() != 0) begin
      taps     = (k == pend_key) ? taps + 1 : 1;  // Same key cycles and a new key restarts
      pend_key = k;
    end else if (k == keypad_pkg::KEY_STAR && pend_key != '0) begin
      letters  = key_letters(pend_key);
      exp_lv   = 1'b1;
      exp_ch   = letters[(taps - 1) % letters.len()];
      pend_key = '0;
      if (!model_over && exp_q.size() < text_pkg::WORD_LEN) begin
        exp_q.push_back(exp_ch);                   // Full word drops it
      end
    end else if (k == keypad_pkg::KEY_0) begin
      pend_key = '0;
    end else if (k == keypad_pkg::KEY_HASH) begin
      pend_key = '0;                               // Unsubmitted letter lost
      exp_wv   = !model_over;
      exp_n    = text_pkg::word_count_t'(exp_q.size());
      foreach (exp_q[i]) exp_w[8*i +: 8] = exp_q[i];
      exp_q.delete();
    end else if (k == keypad_pkg::KEY_C) begin
      pend_key   = '0;
      model_over = 1'b1;
      exp_q.delete();
    end

    lc0 = letter_seen;
    wc0 = word_seen;
    @(posedge clk);
    #2 pressed = k;
    if (exp_lv || exp_wv) begin
      while (letter_seen == lc0 && word_seen == wc0) begin
        @(posedge clk);                            // Watchdog bounds this
      end
    end
    repeat (HOLD_CYCLES) @(posedge clk);
    #2 pressed = '0;
    repeat (HOLD_CYCLES) @(posedge clk);

    check_flag((letter_seen - lc0) == (exp_lv ? 1 : 0), 1'b1, "letter_valid pulse count");
    check_flag((word_seen - wc0) == (exp_wv ? 1 : 0), 1'b1, "word_valid pulse count");
    if (exp_lv) check_char(got_letter, exp_ch, "letter");
    if (exp_wv) begin
      check_word(got_word, exp_w, "word");
      check_count(got_count, exp_n, "word_count");
    end
    check_flag(game_over, model_over, "game_over");
  endtask

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    abort_run("Timeout: an expected letter_valid or word_valid pulse never arrived");
  end

  initial begin
    keypad_pkg::key_code_t k;
    int                    n;
    nRst       = 1'b0;
    pressed    = '0;
    pend_key   = '0;
    taps       = 0;
    model_over = 1'b0;
    repeat (2) @(posedge clk);
    #2 nRst = 1'b1;
    @(negedge clk);
    check_flag(letter_valid, 1'b0, "letter_valid after reset");
    check_flag(word_valid, 1'b0, "word_valid after reset");
    check_flag(game_over, 1'b0, "game_over after reset");
    check_count(word_count, '0, "word_count after reset");
    check_flag($onehot(col), 1'b1, "col one-hot after reset");

    // Random tap runs with a word every four letters
    for (int r = 0; r < ROUNDS; r++) begin
      k = LETTER_KEYS[$unsigned($random(seed)) % 8];
      n = 1 + int'($unsigned($random(seed)) % 6);
      repeat (n) do_press(k);
      do_press(keypad_pkg::KEY_STAR);
      if (r % 4 == 3) do_press(keypad_pkg::KEY_HASH);
    end

    // Key change restarts at the first letter
    k = LETTER_KEYS[$unsigned($random(seed)) % 8];
    do_press(k);
    do_press(k);
    do_press((k == keypad_pkg::KEY_5) ? keypad_pkg::KEY_8 : keypad_pkg::KEY_5);
    do_press(keypad_pkg::KEY_STAR);
    do_press(k);
    do_press(keypad_pkg::KEY_0);                   // Pending letter gone
    do_press(keypad_pkg::KEY_STAR);
    do_press(k);
    do_press(IGNORED_KEYS[$unsigned($random(seed)) % 4]);
    do_press(k);                                   // Still the second tap
    do_press(keypad_pkg::KEY_STAR);
    do_press(keypad_pkg::KEY_HASH);

    // Six letters into a five letter word
    for (int i = 0; i < 6; i++) begin
      do_press(LETTER_KEYS[$unsigned($random(seed)) % 8]);
      do_press(keypad_pkg::KEY_STAR);
    end
    do_press(keypad_pkg::KEY_HASH);
    do_press(keypad_pkg::KEY_HASH);                // Empty word

    // Game end freezes the buffer
    do_press(keypad_pkg::KEY_2);
    do_press(keypad_pkg::KEY_STAR);
    do_press(keypad_pkg::KEY_C);
    do_press(k);
    do_press(keypad_pkg::KEY_STAR);                // Letter still shows
    do_press(keypad_pkg::KEY_HASH);
    check_count(word_count, '0, "word_count after game end");

    @(negedge clk);                                // Last assertion results are in
    if (dut.u_scanner.u_scan_assert.fail_cnt == 0 &&
        dut.u_fsm.u_fsm_assert.fail_cnt == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      abort_run("A bound assertion failed");
    end
  end

endmodule
